// File: common/rcn_params.svh
`ifndef RCN_PARAMS_SVH
`define RCN_PARAMS_SVH

// Byte address windows on the 24-bit ring
`define RCN_RAM_BASE      24'h000000
`define RCN_RAM_WORDS     256
`define RCN_TESTREGS_BASE 24'hFFFFF0
`define RCN_DMA_BASE      24'hFFFEC0

// Master IDs
`define RCN_HOST_ID       4'd0
`define RCN_DMA_ID        4'd1

`endif

// File: common/rcn_pkg.sv
package rcn_pkg;

    localparam int RCN_ID_W   = 4;
    localparam int RCN_SEQ_W  = 2;
    localparam int RCN_MASK_W = 4;
    localparam int RCN_ADDR_W = 22;  // Word address, byte address bits 23:2
    localparam int RCN_DATA_W = 32;

    // One ring slot, 67 bits
    typedef struct packed {
        logic                  valid;
        logic                  req;  // 0 once a slave has answered
        logic                  wr;
        logic [RCN_ID_W-1:0]   id;
        logic [RCN_SEQ_W-1:0]  seq;
        logic [RCN_MASK_W-1:0] mask;
        logic [RCN_ADDR_W-1:0] addr;
        logic [RCN_DATA_W-1:0] data;
    } rcn_pkt_t;

    // Byte address inside [base, base + size)
    function automatic logic rcn_in_window(
        input logic [RCN_ADDR_W+1:0] byte_addr,
        input logic [RCN_ADDR_W+1:0] base,
        input logic [RCN_ADDR_W+1:0] size
    );
        logic [RCN_ADDR_W+1:0] offset;
        offset = byte_addr - base;
        return (byte_addr >= base) && (offset < size);
    endfunction

    function automatic logic [RCN_DATA_W-1:0] rcn_mask_merge(
        input logic [RCN_DATA_W-1:0] old_data,
        input logic [RCN_DATA_W-1:0] new_data,
        input logic [RCN_MASK_W-1:0] mask
    );
        logic [RCN_DATA_W-1:0] result;
        result = old_data;
        for (int b = 0; b < RCN_MASK_W; b++) begin
            if (mask[b]) result[8*b +: 8] = new_data[8*b +: 8];
        end
        return result;
    endfunction

endpackage

// File: verilog/rcn_master.sv
`timescale 1ns/1ps

`include "rcn_params.svh"

module rcn_master import rcn_pkg::*; #(
    parameter logic [RCN_ID_W-1:0] MASTER_ID = `RCN_HOST_ID
) (
    input  logic        clk_50,
    input  logic        rst_n,
    input  rcn_pkt_t    rcn_in,
    output rcn_pkt_t    rcn_out,
    input  logic        req,
    input  logic        wr,
    input  logic [23:0] addr,
    input  logic [3:0]  mask,
    input  logic [31:0] wdata,
    output logic        busy,
    output logic        done,
    output logic        err,
    output logic [31:0] rdata
);

    logic                  pend_q;  // Latched, waiting for an empty slot
    logic                  wait_q;  // Out on the ring
    logic [RCN_SEQ_W-1:0]  seq_q;
    logic                  wr_q;
    logic [RCN_ADDR_W-1:0] addr_q;
    logic [RCN_MASK_W-1:0] mask_q;
    logic [RCN_DATA_W-1:0] wdata_q;
    logic                  accept;
    logic                  inject;
    logic                  mine;
    rcn_pkt_t              req_pkt;
    rcn_pkt_t              nxt_out;

    assign busy   = pend_q | wait_q;
    assign accept = req && !busy;
    assign inject = pend_q && !rcn_in.valid;
    assign mine   = wait_q && rcn_in.valid && (rcn_in.id == MASTER_ID) &&
                    (rcn_in.seq == seq_q);

    always_comb begin
        req_pkt       = '0;
        req_pkt.valid = 1'b1;
        req_pkt.req   = 1'b1;
        req_pkt.wr    = wr_q;
        req_pkt.id    = MASTER_ID;
        req_pkt.seq   = seq_q;
        req_pkt.mask  = mask_q;
        req_pkt.addr  = addr_q;
        req_pkt.data  = wdata_q;
    end

    // Own packet leaves the ring, whether answered or bounced
    always_comb begin
        nxt_out = rcn_in;
        if (mine) begin
            nxt_out = '0;
        end else if (inject) begin
            nxt_out = req_pkt;
        end
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            rcn_out <= '0;
            pend_q  <= 1'b0;
            wait_q  <= 1'b0;
            seq_q   <= '0;
            done    <= 1'b0;
            err     <= 1'b0;
        end else begin
            rcn_out <= nxt_out;
            done    <= mine;
            if (accept) begin
                pend_q <= 1'b1;
                seq_q  <= seq_q + 1'b1;
            end else if (inject) begin
                pend_q <= 1'b0;
                wait_q <= 1'b1;
            end
            if (mine) begin
                wait_q <= 1'b0;
                err    <= rcn_in.req;  // Still a request, nobody claimed it
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (accept) begin
            wr_q    <= wr;
            addr_q  <= addr[23:2];
            mask_q  <= mask;
            wdata_q <= wdata;
        end
        if (mine) rdata <= rcn_in.data;
    end

endmodule

// File: verilog/rcn_ram.sv
`timescale 1ns/1ps

`include "rcn_params.svh"

module rcn_ram import rcn_pkg::*; #(
    parameter logic [23:0] ADDR_BASE = `RCN_RAM_BASE
) (
    input  logic     clk_50,
    input  logic     rst_n,
    input  rcn_pkt_t rcn_in,
    output rcn_pkt_t rcn_out
);

    localparam int          IDX_W    = $clog2(`RCN_RAM_WORDS);
    localparam logic [23:0] WIN_SIZE = 24'(`RCN_RAM_WORDS * 4);

    logic [RCN_DATA_W-1:0] mem [`RCN_RAM_WORDS];
    logic                  hit;
    logic [RCN_ADDR_W-1:0] word_off;
    logic [IDX_W-1:0]      idx;

    assign hit = rcn_in.valid && rcn_in.req &&
                 rcn_in_window({rcn_in.addr, 2'b00}, ADDR_BASE, WIN_SIZE);
    assign word_off = rcn_in.addr - ADDR_BASE[23:2];
    assign idx      = word_off[IDX_W-1:0];

    always_ff @(posedge clk_50) begin
        if (hit && rcn_in.wr) begin
            for (int b = 0; b < RCN_MASK_W; b++) begin
                if (rcn_in.mask[b]) mem[idx][8*b +: 8] <= rcn_in.data[8*b +: 8];
            end
        end
    end

    // Answer in the same slot, write data is echoed back
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            rcn_out <= '0;
        end else begin
            rcn_out <= rcn_in;
            if (hit) begin
                rcn_out.req <= 1'b0;
                if (!rcn_in.wr) rcn_out.data <= mem[idx];
            end
        end
    end

endmodule

// File: verilog/rcn_testregs.sv
`timescale 1ns/1ps

`include "rcn_params.svh"

module rcn_testregs import rcn_pkg::*; #(
    parameter logic [23:0] ADDR_BASE = `RCN_TESTREGS_BASE
) (
    input  logic        clk_50,
    input  logic        rst_n,
    input  rcn_pkt_t    rcn_in,
    output rcn_pkt_t    rcn_out,
    output logic [31:0] test_progress,
    output logic [31:0] test_fail,
    output logic [31:0] test_pass
);

    localparam logic [23:0] WIN_SIZE = 24'd16;

    logic                  hit;
    logic [1:0]            sel;  // Word within the window
    logic [RCN_DATA_W-1:0] rd_data;

    assign hit = rcn_in.valid && rcn_in.req &&
                 rcn_in_window({rcn_in.addr, 2'b00}, ADDR_BASE, WIN_SIZE);
    assign sel = rcn_in.addr[1:0];

    always_comb begin
        case (sel)
            2'd0:    rd_data = test_progress;
            2'd1:    rd_data = test_fail;
            2'd2:    rd_data = test_pass;
            default: rd_data = '0;  // Offset 12 unused
        endcase
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            rcn_out       <= '0;
            test_progress <= '0;
            test_fail     <= '0;
            test_pass     <= '0;
        end else begin
            rcn_out <= rcn_in;
            if (hit) begin
                rcn_out.req <= 1'b0;
                if (!rcn_in.wr) rcn_out.data <= rd_data;
            end
            if (hit && rcn_in.wr) begin
                case (sel)
                    2'd0: test_progress <= rcn_mask_merge(test_progress, rcn_in.data, rcn_in.mask);
                    2'd1: test_fail <= rcn_mask_merge(test_fail, rcn_in.data, rcn_in.mask);
                    2'd2: test_pass <= rcn_mask_merge(test_pass, rcn_in.data, rcn_in.mask);
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: verilog/rcn_dma.sv
`timescale 1ns/1ps

`include "rcn_params.svh"

module rcn_dma import rcn_pkg::*; #(
    parameter logic [23:0] ADDR_BASE = `RCN_DMA_BASE
) (
    input  logic     clk_50,
    input  logic     rst_n,
    input  rcn_pkt_t rcn_in,
    output rcn_pkt_t rcn_out,
    output logic     dma_done
);

    typedef enum logic [2:0] {ST_IDLE, ST_RD, ST_RD_WAIT, ST_WR, ST_WR_WAIT} state_t;

    localparam logic [23:0] WIN_SIZE = 24'd16;

    rcn_pkt_t    slv_out;  // Slave stage output, into the inner master
    logic        hit;
    logic [1:0]  sel;
    logic [31:0] rd_data;
    logic [31:0] src_q;
    logic [31:0] dst_q;
    logic [31:0] len_q;
    logic        go_q;
    state_t      state_q;
    logic [31:0] cnt_q;
    logic [31:0] buf_q;
    logic        m_req;
    logic        m_wr;
    logic [23:0] m_addr;
    logic        m_busy;
    logic        m_done;
    logic        m_err;
    logic [31:0] m_rdata;

    assign hit = rcn_in.valid && rcn_in.req &&
                 rcn_in_window({rcn_in.addr, 2'b00}, ADDR_BASE, WIN_SIZE);
    assign sel = rcn_in.addr[1:0];

    always_comb begin
        case (sel)
            2'd0:    rd_data = src_q;
            2'd1:    rd_data = dst_q;
            2'd2:    rd_data = len_q;
            default: rd_data = {31'd0, dma_done};
        endcase
    end

    // Answer in the slot, the inner master registers it
    always_comb begin
        slv_out = rcn_in;
        if (hit) begin
            slv_out.req = 1'b0;
            if (!rcn_in.wr) slv_out.data = rd_data;
        end
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            src_q <= '0;
            dst_q <= '0;
            len_q <= '0;
            go_q  <= 1'b0;
        end else begin
            go_q <= hit && rcn_in.wr && (sel == 2'd3);  // Any write to start
            if (hit && rcn_in.wr) begin
                case (sel)
                    2'd0:    src_q <= rcn_mask_merge(src_q, rcn_in.data, rcn_in.mask);
                    2'd1:    dst_q <= rcn_mask_merge(dst_q, rcn_in.data, rcn_in.mask);
                    2'd2:    len_q <= rcn_mask_merge(len_q, rcn_in.data, rcn_in.mask);
                    default: ;
                endcase
            end
        end
    end

    assign m_req  = ((state_q == ST_RD) || (state_q == ST_WR)) && !m_busy;
    assign m_wr   = (state_q == ST_WR);
    assign m_addr = (m_wr ? dst_q[23:0] : src_q[23:0]) + {cnt_q[21:0], 2'b00};

    // Copy sequencer, one read then one write per word
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            cnt_q    <= '0;
            dma_done <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (go_q) begin
                        cnt_q    <= '0;
                        dma_done <= (len_q == '0);
                        state_q  <= (len_q == '0) ? ST_IDLE : ST_RD;
                    end
                end
                ST_RD: if (m_req) state_q <= ST_RD_WAIT;
                ST_RD_WAIT: begin
                    if (m_done && m_err) begin
                        dma_done <= 1'b1;  // Abort on a bad source
                        state_q  <= ST_IDLE;
                    end else if (m_done) begin
                        state_q <= ST_WR;
                    end
                end
                ST_WR: if (m_req) state_q <= ST_WR_WAIT;
                ST_WR_WAIT: begin
                    if (m_done && (m_err || cnt_q == len_q - 1'b1)) begin
                        dma_done <= 1'b1;
                        state_q  <= ST_IDLE;
                    end else if (m_done) begin
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= ST_RD;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if ((state_q == ST_RD_WAIT) && m_done) buf_q <= m_rdata;
    end

    rcn_master #(.MASTER_ID(`RCN_DMA_ID)) dma_master (
        .clk_50 (clk_50),
        .rst_n  (rst_n),
        .rcn_in (slv_out),
        .rcn_out(rcn_out),
        .req    (m_req),
        .wr     (m_wr),
        .addr   (m_addr),
        .mask   (4'hF),
        .wdata  (buf_q),
        .busy   (m_busy),
        .done   (m_done),
        .err    (m_err),
        .rdata  (m_rdata)
    );

endmodule

// File: verilog/rcn_subsys_top.sv
`timescale 1ns/1ps

`include "rcn_params.svh"

module rcn_subsys_top import rcn_pkg::*; (
    input  logic        clk_50,
    input  logic        rst_n,

    input  logic        host_req,
    input  logic        host_wr,
    input  logic [23:0] host_addr,
    input  logic [3:0]  host_mask,
    input  logic [31:0] host_wdata,
    output logic        host_busy,
    output logic        host_done,
    output logic        host_err,
    output logic [31:0] host_rdata,

    output logic [31:0] test_progress,
    output logic [31:0] test_fail,
    output logic [31:0] test_pass,
    output logic        dma_done
);

    // Ring segments, host -> testregs -> ram -> dma -> host
    rcn_pkt_t rcn_0;
    rcn_pkt_t rcn_1;
    rcn_pkt_t rcn_2;
    rcn_pkt_t rcn_3;

    rcn_master #(.MASTER_ID(`RCN_HOST_ID)) host (
        .clk_50 (clk_50),
        .rst_n  (rst_n),
        .rcn_in (rcn_0),
        .rcn_out(rcn_1),
        .req    (host_req),
        .wr     (host_wr),
        .addr   (host_addr),
        .mask   (host_mask),
        .wdata  (host_wdata),
        .busy   (host_busy),
        .done   (host_done),
        .err    (host_err),
        .rdata  (host_rdata)
    );

    rcn_testregs #(.ADDR_BASE(`RCN_TESTREGS_BASE)) rcn_testregs (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .rcn_in       (rcn_1),
        .rcn_out      (rcn_2),
        .test_progress(test_progress),
        .test_fail    (test_fail),
        .test_pass    (test_pass)
    );

    rcn_ram #(.ADDR_BASE(`RCN_RAM_BASE)) sram (
        .clk_50 (clk_50),
        .rst_n  (rst_n),
        .rcn_in (rcn_2),
        .rcn_out(rcn_3)
    );

    rcn_dma #(.ADDR_BASE(`RCN_DMA_BASE)) rcn_dma (
        .clk_50  (clk_50),
        .rst_n   (rst_n),
        .rcn_in  (rcn_3),
        .rcn_out (rcn_0),
        .dma_done(dma_done)
    );

endmodule

// File: dv/rcn_subsys_tb.sv
`timescale 1ns/1ps

`include "rcn_params.svh"

module rcn_subsys_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk_50;
    logic        rst_n;
    logic        host_req;
    logic        host_wr;
    logic [23:0] host_addr;
    logic [3:0]  host_mask;
    logic [31:0] host_wdata;
    logic        host_busy;
    logic        host_done;
    logic        host_err;
    logic [31:0] host_rdata;
    logic [31:0] test_progress;
    logic [31:0] test_fail;
    logic [31:0] test_pass;
    logic        dma_done;

    rcn_subsys_top dut (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .host_req     (host_req),
        .host_wr      (host_wr),
        .host_addr    (host_addr),
        .host_mask    (host_mask),
        .host_wdata   (host_wdata),
        .host_busy    (host_busy),
        .host_done    (host_done),
        .host_err     (host_err),
        .host_rdata   (host_rdata),
        .test_progress(test_progress),
        .test_fail    (test_fail),
        .test_pass    (test_pass),
        .dma_done     (dma_done)
    );

    always #50 clk_50 = ~clk_50;  // 100 ns period

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_failure($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // One host transaction that returns in the cycle of host_done
    task automatic host_access(input logic wr, input logic [23:0] addr,
                               input logic [3:0] mask, input logic [31:0] wdata);
        int cycles;
        @(posedge clk_50);
        #5;
        host_req   = 1'b1;
        host_wr    = wr;
        host_addr  = addr;
        host_mask  = mask;
        host_wdata = wdata;
        @(posedge clk_50);
        #5;
        host_req = 1'b0;
        cycles   = 0;
        @(negedge clk_50);
        while (!host_done) begin
            if (cycles >= TIMEOUT_CYCLES) stop_with_failure("Timeout waiting for host_done");
            @(negedge clk_50);
            cycles++;
        end
    endtask

    task automatic wait_dma_done();
        int cycles;
        cycles = 0;
        @(negedge clk_50);
        while (!dma_done) begin
            if (cycles >= TIMEOUT_CYCLES) stop_with_failure("Timeout waiting for dma_done");
            @(negedge clk_50);
            cycles++;
        end
    endtask

    task automatic run_command(input logic [7:0] op, input logic [23:0] addr,
                               input logic [3:0] mask, input logic [31:0] wdata,
                               input logic [31:0] expected);
        logic [23:0] offset;
        offset = addr - `RCN_TESTREGS_BASE;
        case (op)
            "W": begin
                host_access(1'b1, addr, mask, wdata);
                assert (host_err == expected[0])
                    else report_mismatch("host_err", {31'd0, host_err}, expected);
            end
            "R": begin
                host_access(1'b0, addr, mask, wdata);
                assert (host_err == 1'b0)
                    else report_mismatch("host_err", {31'd0, host_err}, 32'd0);
                assert (host_rdata == expected)
                    else report_mismatch("host_rdata", host_rdata, expected);
            end
            "T": begin
                case (offset)
                    24'h0: assert (test_progress == expected)
                        else report_mismatch("test_progress", test_progress, expected);
                    24'h4: assert (test_fail == expected)
                        else report_mismatch("test_fail", test_fail, expected);
                    24'h8: assert (test_pass == expected)
                        else report_mismatch("test_pass", test_pass, expected);
                    default: stop_with_failure("T line does not name a test register");
                endcase
            end
            "D": begin
                wait_dma_done();
            end
            default: stop_with_failure($sformatf("Unknown op '%c' in testdata file", op));
        endcase
    endtask

    initial begin
        int               fd;
        int               n;
        logic             eof_seen;
        logic [7:0]       op;
        logic [23:0]      addr;
        logic [3:0]       mask;
        logic [31:0]      wdata;
        logic [31:0]      expected;
        logic [8*128-1:0] skip_line;

        clk_50     = 1'b0;
        rst_n      = 1'b0;
        host_req   = 1'b0;
        host_wr    = 1'b0;
        host_addr  = '0;
        host_mask  = '0;
        host_wdata = '0;
        repeat (4) @(posedge clk_50);
        #5;
        rst_n = 1'b1;

        @(negedge clk_50);
        assert (host_busy == 1'b0) else report_mismatch("host_busy", {31'd0, host_busy}, 32'd0);
        assert (host_done == 1'b0) else report_mismatch("host_done", {31'd0, host_done}, 32'd0);
        assert (dma_done == 1'b0) else report_mismatch("dma_done", {31'd0, dma_done}, 32'd0);
        assert (test_progress == 32'd0)
            else report_mismatch("test_progress", test_progress, 32'd0);
        assert (test_fail == 32'd0) else report_mismatch("test_fail", test_fail, 32'd0);
        assert (test_pass == 32'd0) else report_mismatch("test_pass", test_pass, 32'd0);

        fd = $fopen("dv/rcn_testdata.txt", "r");
        if (fd == 0) stop_with_failure("Cannot open dv/rcn_testdata.txt");
        eof_seen = 1'b0;
        while (!eof_seen) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                eof_seen = 1'b1;
            end else if (op == "#") begin
                n = $fgets(skip_line, fd);  // Comment line
            end else begin
                n = $fscanf(fd, "%h %h %h %h", addr, mask, wdata, expected);
                if (n != 4) stop_with_failure("Malformed line in testdata file");
                run_command(op, addr, mask, wdata, expected);
            end
        end
        $fclose(fd);

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: dv/rcn_testdata.txt
# op addr(byte, hex) mask data expected
# W: expected host_err  R: expected read data  T: expected test register  D: expected dma_done
W 000010 F 12345678 00000000
R 000010 F 00000000 12345678
W 000014 F AABBCCDD 00000000
W 000014 5 11223344 00000000
R 000014 F 00000000 AA22CC44
W FFFFF0 F 00000003 00000000
T FFFFF0 F 00000000 00000003
W FFFFF4 F 0000BAD0 00000000
T FFFFF4 F 00000000 0000BAD0
W FFFFF8 F 600DC0DE 00000000
T FFFFF8 F 00000000 600DC0DE
R FFFFF8 F 00000000 600DC0DE
W 000040 F 01010101 00000000
W 000044 F 02020202 00000000
W 000048 F 03030303 00000000
W FFFEC0 F 00000040 00000000
W FFFEC4 F 00000080 00000000
W FFFEC8 F 00000003 00000000
W FFFECC F 00000001 00000000
D 000000 0 00000000 00000001
R 000080 F 00000000 01010101
R 000084 F 00000000 02020202
R 000088 F 00000000 03030303
W 800000 F DEADBEEF 00000001

// File: filelist.f
+incdir+common
common/rcn_pkg.sv
verilog/rcn_master.sv
verilog/rcn_ram.sv
verilog/rcn_testregs.sv
verilog/rcn_dma.sv
verilog/rcn_subsys_top.sv
dv/rcn_subsys_tb.sv

// File: Bender.yml
package:
  name: rcn_subsys

export_include_dirs:
  - common

sources:
  - common/rcn_pkg.sv
  - verilog/rcn_master.sv
  - verilog/rcn_ram.sv
  - verilog/rcn_testregs.sv
  - verilog/rcn_dma.sv
  - verilog/rcn_subsys_top.sv
  - target: simulation
    files:
      - dv/rcn_subsys_tb.sv
